//--- hw/i2c_line_filter.sv
// scl/sda synchronizer, glitch filter, edge and start/stop detector
`include "i2c_regs_defines.svh"

module i2c_line_filter (
    input  logic clk,
    input  logic rst,
    input  logic scl_i,
    input  logic sda_i,
    output logic scl,
    output logic sda,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_cond,
    output logic stop_cond,
    output logic bus_active
);

    // sample history, doubles as the synchronizer
    logic [`I2C_FILTER_LEN-1:0] scl_sr;
    logic [`I2C_FILTER_LEN-1:0] sda_sr;

    // filtered levels one clock back, for edges
    logic scl_q;
    logic sda_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            scl_sr     <= '1;
            sda_sr     <= '1;
            scl        <= 1'b1;
            sda        <= 1'b1;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            scl_rise   <= 1'b0;
            scl_fall   <= 1'b0;
            start_cond <= 1'b0;
            stop_cond  <= 1'b0;
            bus_active <= 1'b0;
        end else begin
            scl_sr <= {scl_sr[`I2C_FILTER_LEN-2:0], scl_i};
            sda_sr <= {sda_sr[`I2C_FILTER_LEN-2:0], sda_i};
            // level moves only when every sample agrees
            if (scl_sr == '1) begin
                scl <= 1'b1;
            end else if (scl_sr == '0) begin
                scl <= 1'b0;
            end
            if (sda_sr == '1) begin
                sda <= 1'b1;
            end else if (sda_sr == '0) begin
                sda <= 1'b0;
            end
            scl_q <= scl;
            sda_q <= sda;
            // single-cycle pulses, one clock after the level
            scl_rise <= scl && !scl_q;
            scl_fall <= !scl && scl_q;
            // sda moving while scl high is a bus condition
            start_cond <= !sda && sda_q && scl;
            stop_cond  <= sda && !sda_q && scl;
            if (start_cond) begin
                bus_active <= 1'b1;
            end else if (stop_cond) begin
                bus_active <= 1'b0;
            end
        end
    end

endmodule

//--- hw/i2c_reg_ctrl.sv
// register pointer logic mapping the i2c byte stream onto register accesses
`include "i2c_regs_defines.svh"

module i2c_reg_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  i2c_regs_pkg::reg_data_t rx_data,
    input  logic                    rx_valid,
    input  logic                    rx_last,
    input  logic                    tx_ready,
    input  i2c_regs_pkg::reg_data_t i2c_rdata,
    output logic                    rx_ready,
    output i2c_regs_pkg::reg_data_t tx_data,
    output logic                    tx_valid,
    output logic                    i2c_we,
    output i2c_regs_pkg::reg_ptr_t  i2c_ptr,
    output i2c_regs_pkg::reg_data_t i2c_wdata
);

    // high from the first clock after reset
    logic run_q;
    // next rx byte is a pointer byte
    logic first_byte;
    logic rx_xfer;
    logic tx_xfer;
    i2c_regs_pkg::reg_ptr_t ptr_inc;

    assign rx_ready = run_q;
    assign tx_valid = run_q;
    assign rx_xfer  = rx_valid && rx_ready;
    assign tx_xfer  = tx_valid && tx_ready;

    // read data straight from the bank at the pointer
    assign tx_data = i2c_rdata;

    // wrap at the top of the bank
    assign ptr_inc = (i2c_ptr == i2c_regs_pkg::reg_ptr_t'(`REG_COUNT - 1)) ?
        '0 : i2c_ptr + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q      <= 1'b0;
            first_byte <= 1'b1;
            i2c_we     <= 1'b0;
            i2c_ptr    <= '0;
        end else begin
            run_q  <= 1'b1;
            i2c_we <= rx_xfer && !first_byte;
            if (rx_xfer) begin
                // last byte of a write rearms the pointer load
                first_byte <= rx_last;
            end
            if (rx_xfer && first_byte) begin
                i2c_ptr <= rx_data[`REG_PTR_W-1:0];
            end else if (i2c_we || tx_xfer) begin
                // step along with the write landing or the byte sent
                i2c_ptr <= ptr_inc;
            end
        end
    end

    // write payload
    always_ff @(posedge clk) begin
        if (rx_xfer) begin
            i2c_wdata <= rx_data;
        end
    end

endmodule

//--- hw/i2c_reg_top.sv
// top level connecting line filter, i2c target, register controller and bank
module i2c_reg_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     scl_i,
    input  logic                     sda_i,
    output logic                     scl_o,
    output logic                     sda_o,
    input  i2c_regs_pkg::i2c_addr_t  device_address,
    input  logic                     wb_cyc,
    input  logic                     wb_stb,
    input  logic                     wb_we,
    input  i2c_regs_pkg::reg_ptr_t   wb_adr,
    input  i2c_regs_pkg::reg_data_t  wb_dat_w,
    output i2c_regs_pkg::reg_data_t  wb_dat_r,
    output logic                     wb_ack,
    output logic                     busy,
    output logic                     bus_active
);

    // filtered lines and events
    logic scl, sda, scl_rise, scl_fall, start_cond, stop_cond;

    // byte streams
    i2c_regs_pkg::reg_data_t rx_data, tx_data;
    logic rx_valid, rx_ready, rx_last, tx_valid, tx_ready;

    // register access
    logic i2c_we;
    i2c_regs_pkg::reg_ptr_t i2c_ptr;
    i2c_regs_pkg::reg_data_t i2c_wdata, i2c_rdata;

    i2c_line_filter u_filter (
        .clk(clk), .rst(rst), .scl_i(scl_i), .sda_i(sda_i),
        .scl(scl), .sda(sda), .scl_rise(scl_rise), .scl_fall(scl_fall),
        .start_cond(start_cond), .stop_cond(stop_cond), .bus_active(bus_active)
    );

    i2c_target u_target (
        .clk(clk), .rst(rst), .scl(scl), .sda(sda),
        .scl_rise(scl_rise), .scl_fall(scl_fall),
        .start_cond(start_cond), .stop_cond(stop_cond),
        .device_address(device_address), .rx_ready(rx_ready),
        .tx_data(tx_data), .tx_valid(tx_valid),
        .scl_o(scl_o), .sda_o(sda_o), .rx_data(rx_data), .rx_valid(rx_valid),
        .rx_last(rx_last), .tx_ready(tx_ready), .busy(busy)
    );

    i2c_reg_ctrl u_ctrl (
        .clk(clk), .rst(rst), .rx_data(rx_data), .rx_valid(rx_valid),
        .rx_last(rx_last), .tx_ready(tx_ready), .i2c_rdata(i2c_rdata),
        .rx_ready(rx_ready), .tx_data(tx_data), .tx_valid(tx_valid),
        .i2c_we(i2c_we), .i2c_ptr(i2c_ptr), .i2c_wdata(i2c_wdata)
    );

    reg_bank u_bank (
        .clk(clk), .rst(rst), .i2c_we(i2c_we), .i2c_ptr(i2c_ptr),
        .i2c_wdata(i2c_wdata), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .i2c_rdata(i2c_rdata),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

endmodule

//--- hw/i2c_regs_defines.svh
// filter length, register count, pointer width and i2c address width macros
`ifndef I2C_REGS_DEFINES_SVH
`define I2C_REGS_DEFINES_SVH

// samples a line must hold before the filtered level follows
`define I2C_FILTER_LEN 4

// size of the register bank
`define REG_COUNT 16

// pointer width, log2 of the register count
`define REG_PTR_W 4

// 7-bit addressing only
`define I2C_ADDR_W 7

`endif

//--- hw/i2c_regs_pkg.sv
// vector typedefs and the i2c target state enum
`include "i2c_regs_defines.svh"

package i2c_regs_pkg;

    // one register, also one byte on the bus
    typedef logic [7:0] reg_data_t;

    // register index
    typedef logic [`REG_PTR_W-1:0] reg_ptr_t;

    // device address on the bus
    typedef logic [`I2C_ADDR_W-1:0] i2c_addr_t;

    // byte-level protocol states of the target
    typedef enum logic [2:0] {
        st_idle,
        st_address,
        st_ack,
        st_write_1,
        st_write_2,
        st_read_1,
        st_read_2,
        st_read_3
    } target_state_t;

endpackage

//--- hw/i2c_target.sv
// i2c target protocol engine with clock stretching and delayed-last rx stream
module i2c_target (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   scl,
    input  logic                   sda,
    input  logic                   scl_rise,
    input  logic                   scl_fall,
    input  logic                   start_cond,
    input  logic                   stop_cond,
    input  i2c_regs_pkg::i2c_addr_t device_address,
    input  logic                   rx_ready,
    input  i2c_regs_pkg::reg_data_t tx_data,
    input  logic                   tx_valid,
    output logic                   scl_o,
    output logic                   sda_o,
    output i2c_regs_pkg::reg_data_t rx_data,
    output logic                   rx_valid,
    output logic                   rx_last,
    output logic                   tx_ready,
    output logic                   busy
);

    i2c_regs_pkg::target_state_t state_q, state_d;

    // shift register, address then data
    i2c_regs_pkg::reg_data_t data_q, data_d;
    i2c_regs_pkg::reg_data_t rx_data_q, rx_data_d;

    // data_q holds a full byte
    logic data_valid_q, data_valid_d;
    // rx_data_q holds a byte not yet released
    logic out_valid_q, out_valid_d;
    logic mode_read_q, mode_read_d;
    logic [2:0] bit_cnt_q, bit_cnt_d;
    logic tx_ready_q, tx_ready_d;
    logic rx_valid_q, rx_valid_d;
    logic rx_last_q, rx_last_d;
    logic scl_o_q, scl_o_d;
    logic sda_o_q, sda_o_d;

    // scl fell, or we hold it low and can act now
    logic low_phase;

    assign low_phase = scl_fall || (!scl_o_q && !scl);

    assign scl_o    = scl_o_q;
    assign sda_o    = sda_o_q;
    assign rx_data  = rx_data_q;
    assign rx_valid = rx_valid_q;
    assign rx_last  = rx_last_q;
    assign tx_ready = tx_ready_q;
    assign busy     = (state_q != i2c_regs_pkg::st_idle);

    always_comb begin
        state_d      = state_q;
        data_d       = data_q;
        rx_data_d    = rx_data_q;
        data_valid_d = data_valid_q;
        out_valid_d  = out_valid_q;
        mode_read_d  = mode_read_q;
        bit_cnt_d    = bit_cnt_q;
        tx_ready_d   = 1'b0;
        // valid drops only on a transfer
        rx_valid_d   = rx_valid_q && !rx_ready;
        rx_last_d    = rx_last_q;
        scl_o_d      = scl_o_q;
        sda_o_d      = sda_o_q;

        if (start_cond || stop_cond) begin
            // transaction ends, held byte goes out as the last one
            scl_o_d      = 1'b1;
            sda_o_d      = 1'b1;
            data_valid_d = 1'b0;
            out_valid_d  = 1'b0;
            rx_last_d    = 1'b1;
            rx_valid_d   = rx_valid_d || out_valid_q;
            bit_cnt_d    = 3'd7;
            state_d      = start_cond ? i2c_regs_pkg::st_address : i2c_regs_pkg::st_idle;
        end else begin
            case (state_q)
                i2c_regs_pkg::st_idle: begin
                    scl_o_d      = 1'b1;
                    sda_o_d      = 1'b1;
                    data_valid_d = 1'b0;
                    out_valid_d  = 1'b0;
                end
                i2c_regs_pkg::st_address: begin
                    scl_o_d = 1'b1;
                    sda_o_d = 1'b1;
                    if (scl_rise) begin
                        if (bit_cnt_q != 3'd0) begin
                            bit_cnt_d = bit_cnt_q - 3'd1;
                            data_d    = {data_q[6:0], sda};
                        end else if (data_q[6:0] == device_address) begin
                            // eighth bit is r/w
                            mode_read_d = sda;
                            state_d     = i2c_regs_pkg::st_ack;
                        end else begin
                            // not ours, stay off the bus
                            state_d = i2c_regs_pkg::st_idle;
                        end
                    end
                end
                i2c_regs_pkg::st_ack: begin
                    // pull sda for the ack clock
                    if (scl_fall) begin
                        sda_o_d   = 1'b0;
                        bit_cnt_d = 3'd7;
                        if (mode_read_q) begin
                            tx_ready_d   = 1'b1;
                            data_valid_d = 1'b0;
                            state_d      = i2c_regs_pkg::st_read_1;
                        end else begin
                            state_d = i2c_regs_pkg::st_write_1;
                        end
                    end
                end
                i2c_regs_pkg::st_write_1: begin
                    if (low_phase) begin
                        sda_o_d = 1'b1;
                        if (rx_valid_q && !rx_ready) begin
                            // output still occupied
                            scl_o_d = 1'b0;
                        end else begin
                            scl_o_d = 1'b1;
                            // park the byte, released once the next one completes
                            if (data_valid_q) begin
                                rx_data_d = data_q;
                                rx_last_d = 1'b0;
                            end
                            out_valid_d  = data_valid_q;
                            data_valid_d = 1'b0;
                            state_d      = i2c_regs_pkg::st_write_2;
                        end
                    end
                end
                i2c_regs_pkg::st_write_2: begin
                    if (scl_rise) begin
                        data_d = {data_q[6:0], sda};
                        if (bit_cnt_q != 3'd0) begin
                            bit_cnt_d = bit_cnt_q - 3'd1;
                        end else begin
                            // another byte came, so the parked one was not last
                            rx_valid_d   = rx_valid_d || out_valid_q;
                            out_valid_d  = 1'b0;
                            data_valid_d = 1'b1;
                            state_d      = i2c_regs_pkg::st_ack;
                        end
                    end
                end
                i2c_regs_pkg::st_read_1: begin
                    if (tx_ready_q && tx_valid) begin
                        data_d       = tx_data;
                        data_valid_d = 1'b1;
                    end else begin
                        tx_ready_d = !data_valid_q;
                    end
                    if (low_phase) begin
                        if (!data_valid_q) begin
                            // no byte yet, hold scl
                            scl_o_d = 1'b0;
                        end else begin
                            // msb first
                            scl_o_d = 1'b1;
                            sda_o_d = data_q[7];
                            data_d  = {data_q[6:0], 1'b0};
                            if (bit_cnt_q != 3'd0) begin
                                bit_cnt_d = bit_cnt_q - 3'd1;
                            end else begin
                                state_d = i2c_regs_pkg::st_read_2;
                            end
                        end
                    end
                end
                i2c_regs_pkg::st_read_2: begin
                    // free sda for the controller ack
                    if (scl_fall) begin
                        sda_o_d = 1'b1;
                        state_d = i2c_regs_pkg::st_read_3;
                    end
                end
                i2c_regs_pkg::st_read_3: begin
                    if (scl_rise) begin
                        if (sda) begin
                            // nack ends the read
                            state_d = i2c_regs_pkg::st_idle;
                        end else begin
                            bit_cnt_d    = 3'd7;
                            tx_ready_d   = 1'b1;
                            data_valid_d = 1'b0;
                            state_d      = i2c_regs_pkg::st_read_1;
                        end
                    end
                end
                default: begin
                    state_d = i2c_regs_pkg::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= i2c_regs_pkg::st_idle;
            data_valid_q <= 1'b0;
            out_valid_q  <= 1'b0;
            mode_read_q  <= 1'b0;
            bit_cnt_q    <= 3'd0;
            tx_ready_q   <= 1'b0;
            rx_valid_q   <= 1'b0;
            rx_last_q    <= 1'b0;
            scl_o_q      <= 1'b1;
            sda_o_q      <= 1'b1;
        end else begin
            state_q      <= state_d;
            data_valid_q <= data_valid_d;
            out_valid_q  <= out_valid_d;
            mode_read_q  <= mode_read_d;
            bit_cnt_q    <= bit_cnt_d;
            tx_ready_q   <= tx_ready_d;
            rx_valid_q   <= rx_valid_d;
            rx_last_q    <= rx_last_d;
            scl_o_q      <= scl_o_d;
            sda_o_q      <= sda_o_d;
        end
    end

    // byte payload
    always_ff @(posedge clk) begin
        data_q    <= data_d;
        rx_data_q <= rx_data_d;
    end

endmodule

//--- hw/reg_bank.sv
// register file with an i2c-side port and a wishbone classic host port
`include "i2c_regs_defines.svh"

module reg_bank (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i2c_we,
    input  i2c_regs_pkg::reg_ptr_t  i2c_ptr,
    input  i2c_regs_pkg::reg_data_t i2c_wdata,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  i2c_regs_pkg::reg_ptr_t  wb_adr,
    input  i2c_regs_pkg::reg_data_t wb_dat_w,
    output i2c_regs_pkg::reg_data_t i2c_rdata,
    output i2c_regs_pkg::reg_data_t wb_dat_r,
    output logic                    wb_ack
);

    i2c_regs_pkg::reg_data_t regs [`REG_COUNT];

    // new request, not the one already being acked
    logic wb_req;

    assign wb_req = wb_cyc && wb_stb && !wb_ack;

    // i2c side reads combinationally
    assign i2c_rdata = regs[i2c_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
            if (i2c_we) begin
                regs[i2c_ptr] <= i2c_wdata;
            end
            // host write comes second so it wins a collision
            if (wb_req && wb_we) begin
                regs[wb_adr] <= wb_dat_w;
            end
        end
    end

    // read data, valid alongside ack
    always_ff @(posedge clk) begin
        if (wb_req) begin
            wb_dat_r <= regs[wb_adr];
        end
    end

endmodule

//--- i2c_reg_top.f
+incdir+hw
hw/i2c_regs_pkg.sv
hw/i2c_line_filter.sv
hw/i2c_target.sv
hw/i2c_reg_ctrl.sv
hw/reg_bank.sv
hw/i2c_reg_top.sv
tests/tb_clk_gen.sv
tests/tb_i2c_reg_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the i2c register target testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f i2c_reg_top.f --top-module tb_i2c_reg_top -Mdir obj_dir

out="$(./obj_dir/Vtb_i2c_reg_top)"
echo "$out"

if echo "$out" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi

//--- tests/tb_clk_gen.sv
// testbench clock and reset generator
module tb_clk_gen (
    output logic clk,
    output logic rst
);

    // period of 10
    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset drops on a falling edge, like the other dut inputs
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- tests/tb_i2c_reg_top.sv
// testbench top with bus and controller models, wishbone tasks, reference model and checks
`include "i2c_regs_defines.svh"

module tb_i2c_reg_top;

    localparam i2c_regs_pkg::i2c_addr_t DEV_ADDR   = 7'h2A;
    localparam i2c_regs_pkg::i2c_addr_t OTHER_ADDR = 7'h2B;
    // scl half period of the controller model, in clocks
    localparam int HALF_SCL    = 20;
    localparam int QUARTER_SCL = HALF_SCL / 2;
    // about 40 bytes at about 360 clocks each, plus wishbone traffic and margin
    localparam int TIMEOUT_CYCLES = 40000;

    logic clk;
    logic rst;
    // controller side of the wired-and bus
    logic scl_m, sda_m;
    logic scl_bus, sda_bus;
    logic scl_o, sda_o;
    logic wb_cyc, wb_stb, wb_we, wb_ack;
    i2c_regs_pkg::reg_ptr_t  wb_adr;
    i2c_regs_pkg::reg_data_t wb_dat_w, wb_dat_r;
    logic busy, bus_active;

    // reference copy of the register bank
    i2c_regs_pkg::reg_data_t ref_regs [`REG_COUNT];
    i2c_regs_pkg::reg_data_t wr_buf [8];
    integer seed;
    int errors;
    int test_err_base;
    int tests_run;
    int unsigned cycle_cnt;
    string cur_test;

    tb_clk_gen u_clk_gen (.clk(clk), .rst(rst));

    // either side of the open-drain bus can pull a line low
    assign scl_bus = scl_m & scl_o;
    assign sda_bus = sda_m & sda_o;

    i2c_reg_top u_dut (
        .clk(clk), .rst(rst), .scl_i(scl_bus), .sda_i(sda_bus),
        .scl_o(scl_o), .sda_o(sda_o), .device_address(DEV_ADDR),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .busy(busy), .bus_active(bus_active)
    );

    // a new cycle is acked on the very next clock
    ack_follows_req: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_cyc && wb_stb) |=> wb_ack)
        else begin
            $display("%s: wishbone ack missing one clock after a request", cur_test);
            errors = errors + 1;
        end

    // ack lasts one clock and never comes without a request
    ack_single: assert property (@(posedge clk) disable iff (rst)
        (wb_ack || !(wb_cyc && wb_stb)) |=> !wb_ack)
        else begin
            $display("%s: wishbone ack held too long or without a request", cur_test);
            errors = errors + 1;
        end

    task automatic require(input logic cond, input string msg);
        assert (cond) else begin
            $display("%s: %s", cur_test, msg);
            errors = errors + 1;
        end
    endtask

    task automatic compare_byte(input i2c_regs_pkg::reg_data_t expv,
                                input i2c_regs_pkg::reg_data_t got);
        assert (got == expv) else begin
            $display("ERR %s: expected %02h, actual %02h", cur_test, expv, got);
            errors = errors + 1;
        end
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        test_err_base = errors;
    endtask

    task automatic report_test();
        tests_run = tests_run + 1;
        $display("test %s finished, %0d failures", cur_test, errors - test_err_base);
    endtask

    task automatic wb_write(input i2c_regs_pkg::reg_ptr_t a, input i2c_regs_pkg::reg_data_t d);
        @(negedge clk);
        wb_adr   = a;
        wb_dat_w = d;
        wb_we    = 1'b1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        ref_regs[a] = d;
    endtask

    task automatic wb_read(input i2c_regs_pkg::reg_ptr_t a, output i2c_regs_pkg::reg_data_t d);
        @(negedge clk);
        wb_adr = a;
        wb_we  = 1'b0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        // data valid alongside ack
        d      = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic readback_all();
        i2c_regs_pkg::reg_data_t got;
        for (int a = 0; a < `REG_COUNT; a++) begin
            wb_read(i2c_regs_pkg::reg_ptr_t'(a), got);
            compare_byte(ref_regs[a], got);
        end
    endtask

    // one scl clock that starts and ends with scl low
    task automatic clock_bit(input logic drive, output logic sampled);
        repeat (QUARTER_SCL) @(negedge clk);
        sda_m = drive;
        repeat (QUARTER_SCL) @(negedge clk);
        scl_m = 1'b1;
        // target may stretch
        while (!scl_bus) @(negedge clk);
        repeat (QUARTER_SCL) @(negedge clk);
        sampled = sda_bus;
        repeat (QUARTER_SCL) @(negedge clk);
        scl_m = 1'b0;
    endtask

    // start from idle or repeated start from scl low
    task automatic bus_start();
        repeat (QUARTER_SCL) @(negedge clk);
        sda_m = 1'b1;
        repeat (QUARTER_SCL) @(negedge clk);
        scl_m = 1'b1;
        while (!scl_bus) @(negedge clk);
        repeat (QUARTER_SCL) @(negedge clk);
        sda_m = 1'b0;
        repeat (QUARTER_SCL) @(negedge clk);
        scl_m = 1'b0;
    endtask

    task automatic bus_stop();
        repeat (QUARTER_SCL) @(negedge clk);
        sda_m = 1'b0;
        repeat (QUARTER_SCL) @(negedge clk);
        scl_m = 1'b1;
        while (!scl_bus) @(negedge clk);
        repeat (QUARTER_SCL) @(negedge clk);
        sda_m = 1'b1;
        // bus idle long enough for the filter to settle
        repeat (HALF_SCL) @(negedge clk);
    endtask

    task automatic write_byte(input i2c_regs_pkg::reg_data_t b, output logic nack);
        logic unused;
        for (int i = 7; i >= 0; i--) begin
            clock_bit(b[i], unused);
        end
        // ninth bit is low for an ack
        clock_bit(1'b1, nack);
    endtask

    task automatic read_byte(output i2c_regs_pkg::reg_data_t got, input logic last);
        logic b;
        for (int i = 7; i >= 0; i--) begin
            clock_bit(1'b1, b);
            got[i] = b;
        end
        // nack only after the final byte
        clock_bit(last, b);
    endtask

    // start and device address with write, then the pointer byte
    task automatic open_write(input i2c_regs_pkg::reg_ptr_t ptr);
        logic nack;
        bus_start();
        write_byte({DEV_ADDR, 1'b0}, nack);
        require(!nack, "write address not acknowledged");
        // upper bits of the pointer byte are don't care
        write_byte({4'($random(seed)), ptr}, nack);
        require(!nack, "pointer byte not acknowledged");
    endtask

    task automatic write_regs(input i2c_regs_pkg::reg_ptr_t ptr, input int n);
        logic nack;
        open_write(ptr);
        for (int i = 0; i < n; i++) begin
            write_byte(wr_buf[i], nack);
            require(!nack, "data byte not acknowledged");
            ref_regs[(int'(ptr) + i) % `REG_COUNT] = wr_buf[i];
        end
        bus_stop();
    endtask

    task automatic read_regs(input i2c_regs_pkg::reg_ptr_t ptr, input int n);
        logic nack;
        i2c_regs_pkg::reg_data_t got;
        i2c_regs_pkg::reg_data_t expv;
        open_write(ptr);
        bus_start();
        write_byte({DEV_ADDR, 1'b1}, nack);
        require(!nack, "read address not acknowledged");
        for (int i = 0; i < n; i++) begin
            expv = ref_regs[(int'(ptr) + i) % `REG_COUNT];
            read_byte(got, i == n - 1);
            compare_byte(expv, got);
        end
        // the nack alone returns the target to idle
        require(!busy, "target still busy after the NACK");
        bus_stop();
    endtask

    task automatic check_bus_status();
        start_test("bus_status");
        require(!busy && !bus_active, "status outputs high after reset");
        require(scl_o && sda_o, "bus lines not released after reset");
        // bank cleared by reset
        readback_all();
        open_write(4'd0);
        require(bus_active, "bus_active low inside a transaction");
        require(busy, "busy low inside a transaction");
        bus_stop();
        require(!bus_active, "bus_active still high after STOP");
        require(!busy, $sformatf("target still busy after STOP, state %s",
            u_dut.u_target.state_q.name()));
        require(scl_o && sda_o, "bus lines still pulled low after STOP");
        report_test();
    endtask

    task automatic write_then_readback();
        i2c_regs_pkg::reg_data_t got;
        start_test("i2c_write");
        for (int i = 0; i < 5; i++) begin
            wr_buf[i] = 8'($random(seed));
        end
        // starts near the top so the pointer wraps
        write_regs(4'd13, 5);
        for (int i = 0; i < 5; i++) begin
            wb_read(4'((13 + i) % `REG_COUNT), got);
            compare_byte(wr_buf[i], got);
        end
        report_test();
    endtask

    task automatic read_with_wrap();
        start_test("i2c_read_wrap");
        for (int a = 0; a < `REG_COUNT; a++) begin
            wb_write(i2c_regs_pkg::reg_ptr_t'(a), 8'($random(seed)));
        end
        // 18 bytes from 5 pass register 15 and come back around
        read_regs(4'd5, 18);
        report_test();
    endtask

    task automatic reject_other_address();
        logic nack;
        start_test("addr_mismatch");
        bus_start();
        write_byte({OTHER_ADDR, 1'b0}, nack);
        require(nack, "foreign address was acknowledged");
        write_byte(8'h03, nack);
        write_byte(8'h5A, nack);
        require(nack, "data byte acknowledged after a foreign address");
        bus_stop();
        readback_all();
        report_test();
    endtask

    task automatic host_write_during_read();
        i2c_regs_pkg::reg_data_t newv;
        start_test("wb_during_read");
        newv = ref_regs[9] ^ 8'hA5;
        fork
            read_regs(4'd4, 3);
            begin
                wait (busy);
                // lands in the data phase of the read
                repeat (1500) @(negedge clk);
                require(busy, "read finished before the host write");
                wb_write(4'd9, newv);
            end
        join
        read_regs(4'd9, 1);
        report_test();
    endtask

    // cycle limit for the whole run
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Errors found");
        $finish;
    end

    initial begin
        scl_m     = 1'b1;
        sda_m     = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        seed      = 20;
        errors    = 0;
        tests_run = 0;
        cur_test  = "reset";
        for (int a = 0; a < `REG_COUNT; a++) begin
            ref_regs[a] = '0;
        end
        @(negedge rst);
        repeat (4) @(negedge clk);
        check_bus_status();
        write_then_readback();
        read_with_wrap();
        reject_other_address();
        host_write_during_read();
        $display("tests run: %0d, failed checks: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
